//--- source/divPkg.sv
// Divide unit shared constants, opcode enum and request, operand and result structs

package divPkg;

	// ========================================
	// Widths
	// ========================================

	// Operand and result word width
	localparam int dataWidth = 64;
	// Issue tag width, matches the reorder slot index
	localparam int tagWidth = 6;

	// ========================================
	// Opcodes
	// ========================================

	// Unsigned, signed by register, signed by immediate
	typedef enum logic [1:0] {
		divUnsigned  = 2'd0,
		divSigned    = 2'd1,
		divSignedImm = 2'd2
	} divOp;

	// ========================================
	// Buses
	// ========================================

	// Request from the issue stage
	typedef struct packed {
		logic [tagWidth-1:0]  tag;
		divOp                 op;
		logic [dataWidth-1:0] dividend;
		logic [dataWidth-1:0] divisor;   // Register operand
		logic [dataWidth-1:0] imm;       // Immediate operand
	} divReq;

	// Prepared operands, carried alongside the iteration
	typedef struct packed {
		logic [dataWidth-1:0] dividendMag;
		logic [dataWidth-1:0] divisorMag;
		logic                 negQuotient;
		logic                 negRemainder;
		logic                 zeroDivisor;
		logic [tagWidth-1:0]  tag;
		logic [dataWidth-1:0] dividend;  // Original value, used for divide by zero
	} divOperands;

	// Result back to the pipeline
	typedef struct packed {
		logic [tagWidth-1:0]  tag;
		logic [dataWidth-1:0] quotient;
		logic [dataWidth-1:0] remainder;
		logic                 divByZero;
	} divResult;

endpackage

//--- source/divOperandSelect.sv
// Divisor selection, sign stripping, sign flags and zero divisor detection
`timescale 1ns/1ps

module divOperandSelect import divPkg::*; (
	input  divReq      req,
	output divOperands ops
);

	// ========================================
	// Source selection
	// ========================================

	// Divisor comes from the immediate only for divSignedImm
	logic [dataWidth-1:0] divisorSel;
	// Signed opcodes take magnitudes
	logic isSigned;
	// Effective sign bits, zero for unsigned
	logic dividendSign;
	logic divisorSign;

	always_comb begin
		divisorSel = (req.op == divSignedImm) ? req.imm : req.divisor;
	end

	always_comb begin
		isSigned = (req.op == divSigned) || (req.op == divSignedImm);
	end

	// Sign bits only matter when signed
	always_comb begin
		dividendSign = isSigned & req.dividend[dataWidth-1];
		divisorSign  = isSigned & divisorSel[dataWidth-1];
	end

	// ========================================
	// Operand bundle
	// ========================================

	always_comb begin
		// Two's-complement magnitudes
		// most negative value stays as its unsigned pattern, which is right
		ops.dividendMag = dividendSign ? -req.dividend : req.dividend;
		ops.divisorMag  = divisorSign ? -divisorSel : divisorSel;

		// Quotient negative when signs differ
		ops.negQuotient = dividendSign ^ divisorSign;
		// Remainder follows the dividend
		ops.negRemainder = dividendSign;

		// Zero test on the selected source
		ops.zeroDivisor = (divisorSel == '0);

		// Pass through for the result stage
		ops.tag      = req.tag;
		ops.dividend = req.dividend;
	end

endmodule

//--- source/divCore.sv
// Radix-2 restoring divider on unsigned magnitudes with idle/run/finish FSM
`timescale 1ns/1ps

module divCore import divPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  divOperands           ops,
	output logic                 busy,
	output logic                 done,
	output logic [dataWidth-1:0] quotient,
	output logic [dataWidth-1:0] remainder,
	output divOperands           opsOut
);

	// Iteration counter width, one count per quotient bit
	localparam int cntWidth = $clog2(dataWidth);

	// ========================================
	// State
	// ========================================

	typedef enum logic [1:0] {
		stIdle   = 2'd0,
		stRun    = 2'd1,
		stFinish = 2'd2
	} coreState;

	coreState state;
	logic [cntWidth-1:0] iterCnt;
	// Last iteration of the run state
	logic lastIter;

	// Held operands for the whole divide
	divOperands opsReg;
	// Dividend shifts out the top, quotient bits shift in the bottom
	logic [dataWidth-1:0] quoReg;
	// Partial remainder
	logic [dataWidth-1:0] remReg;

	// ========================================
	// Datapath for one iteration
	// ========================================

	// Remainder shifted left with the next dividend bit
	logic [dataWidth:0] shifted;
	// Remainder after the trial subtract
	logic [dataWidth:0] trial;
	// Divisor fits into the shifted remainder
	logic fits;

	always_comb begin
		shifted = {remReg, quoReg[dataWidth-1]};
		fits    = (shifted >= {1'b0, opsReg.divisorMag});
		trial   = shifted - {1'b0, opsReg.divisorMag};
	end

	always_comb begin
		lastIter = (iterCnt == cntWidth'(dataWidth - 1));
	end

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= stIdle;
			iterCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					// Load on start, count from zero
					if (start) begin
						state   <= stRun;
						iterCnt <= '0;
					end
				end
				stRun: begin
					iterCnt <= iterCnt + 1'b1;
					if (lastIter) begin
						state <= stFinish;
					end
				end
				stFinish: begin
					// One cycle of done, then free again
					state <= stIdle;
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// ========================================
	// Datapath registers
	// ========================================

	always_ff @(posedge clk) begin
		if (state == stIdle && start) begin
			opsReg <= ops;
			quoReg <= ops.dividendMag;
			remReg <= '0;
		end else if (state == stRun) begin
			// Restore by keeping the shifted value when it does not fit
			remReg <= fits ? trial[dataWidth-1:0] : shifted[dataWidth-1:0];
			quoReg <= {quoReg[dataWidth-2:0], fits};
		end
	end

	// ========================================
	// Outputs
	// ========================================

	always_comb begin
		busy = (state != stIdle);
		done = (state == stFinish);
	end

	// Results are stable during the finish cycle
	always_comb begin
		quotient  = quoReg;
		remainder = remReg;
		opsOut    = opsReg;
	end

endmodule

//--- source/divResultFormat.sv
// Sign restore, divide by zero substitution and result register
`timescale 1ns/1ps

module divResultFormat import divPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 done,
	input  logic [dataWidth-1:0] quotient,
	input  logic [dataWidth-1:0] remainder,
	input  divOperands           ops,
	output logic                 resultValid,
	output divResult             result
);

	// ========================================
	// Formatting
	// ========================================

	divResult formatted;

	always_comb begin
		formatted.tag = ops.tag;
		if (ops.zeroDivisor) begin
			// All ones quotient, dividend passes through as remainder
			formatted.quotient  = '1;
			formatted.remainder = ops.dividend;
			formatted.divByZero = 1'b1;
		end else begin
			// Truncate toward zero
			formatted.quotient  = ops.negQuotient ? -quotient : quotient;
			// Remainder keeps the dividend's sign
			formatted.remainder = ops.negRemainder ? -remainder : remainder;
			formatted.divByZero = 1'b0;
		end
	end

	// ========================================
	// Output registers
	// ========================================

	// Strobe, one cycle per finished divide
	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= done;
		end
	end

	// Payload held until the next divide finishes
	always_ff @(posedge clk) begin
		if (done) begin
			result <= formatted;
		end
	end

endmodule

//--- source/divUnit.sv
// Divide unit top level: operand select, iterative core and result formatter
`timescale 1ns/1ps

module divUnit import divPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     reqValid,
	input  divReq    req,
	output logic     busy,
	output logic     resultValid,
	output divResult result
);

	// ========================================
	// Internal nets
	// ========================================

	// Prepared operands from the request
	divOperands ops;
	// Operands carried through the core
	divOperands coreOps;
	// Accepted request, dropped while busy
	logic start;
	// Core finished, one cycle
	logic coreDone;
	// Unsigned core results
	logic [dataWidth-1:0] quotient;
	logic [dataWidth-1:0] remainder;

	// No back-pressure, issue must watch busy
	assign start = reqValid & ~busy;

	// ========================================
	// Pipeline blocks
	// ========================================

	// Divisor choice and sign stripping
	divOperandSelect opSel (
		.req (req),
		.ops (ops)
	);

	// Shift-subtract loop
	divCore core (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.ops       (ops),
		.busy      (busy),
		.done      (coreDone),
		.quotient  (quotient),
		.remainder (remainder),
		.opsOut    (coreOps)
	);

	// Signs back on, tagged result out
	divResultFormat fmt (
		.clk         (clk),
		.rst         (rst),
		.done        (coreDone),
		.quotient    (quotient),
		.remainder   (remainder),
		.ops         (coreOps),
		.resultValid (resultValid),
		.result      (result)
	);

endmodule

//--- tests/divUnit_chk.sv
// Bound checker with assertions on result latency, busy, strobe widths and divide by zero
`timescale 1ns/1ps

module divUnitChk import divPkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     start,
	input logic     busy,
	input logic     coreDone,
	input logic     resultValid,
	input divReq    req,
	input divResult result
);

	// Strobe rises after edge N+65, so it is sampled at edge N+66
	localparam int resultLatency = dataWidth + 2;

	// Failed assertions, read by the testbench
	int failCount = 0;

	// Divisor the request actually selects
	logic [dataWidth-1:0] selDivisor;
	// Zero divisor of the request in flight
	logic pendingZero;

	always_comb begin
		selDivisor = (req.op == divSignedImm) ? req.imm : req.divisor;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pendingZero <= 1'b0;
		end else if (start) begin
			pendingZero <= (selDivisor == '0);
		end
	end

	// ========================================
	// Assertions
	// ========================================

	// Every accepted request, and only those, gives a result
	latencyOk: assert property (@(posedge clk) disable iff (rst)
		resultValid == $past(start, resultLatency))
	else begin
		$error("Result strobe does not follow an accepted request by the fixed latency");
		failCount++;
	end

	busyInReset: assert property (@(posedge clk) rst |=> !busy)
	else begin
		$error("Busy is high after a reset edge");
		failCount++;
	end

	busyAfterStart: assert property (@(posedge clk) disable iff (rst) start |=> busy)
	else begin
		$error("Busy did not rise after an accepted request");
		failCount++;
	end

	// Single cycle strobes
	resultPulse: assert property (@(posedge clk) disable iff (rst) resultValid |=> !resultValid)
	else begin
		$error("Result strobe is longer than one cycle");
		failCount++;
	end

	donePulse: assert property (@(posedge clk) disable iff (rst) coreDone |=> !coreDone)
	else begin
		$error("Core done strobe is longer than one cycle");
		failCount++;
	end

	// Flag set exactly when the selected divisor was zero
	zeroFlag: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> (result.divByZero == pendingZero))
	else begin
		$error("Divide by zero flag disagrees with the selected divisor");
		failCount++;
	end

endmodule

bind divUnit divUnitChk chk (
	.clk         (clk),
	.rst         (rst),
	.start       (start),
	.busy        (busy),
	.coreDone    (coreDone),
	.resultValid (resultValid),
	.req         (req),
	.result      (result)
);

//--- tests/divUnitTb.sv
// Divide unit testbench with clock, reset, six tests, reference model, reporting and timeout
`timescale 1ns/1ps

module divUnitTb import divPkg::*; ();

	// Requests that give a result: 3 + 5 + 2 + 3 + 200 + 3
	localparam int totalRequests = 216;
	localparam int cycleLimit = totalRequests * 70 + 200;

	logic clk;
	logic rst;
	logic reqValid;
	logic busy;
	logic resultValid;
	divReq req;
	divResult result;

	// Expected results of accepted requests, oldest first
	divResult expQ[$];
	divResult want;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int failsBefore = 0;
	int accepted = 0;
	int resultCount = 0;
	int cycles = 0;
	integer seed = 32'hb0b1c23f;

	divUnit uut (
		.clk         (clk),
		.rst         (rst),
		.reqValid    (reqValid),
		.req         (req),
		.busy        (busy),
		.resultValid (resultValid),
		.result      (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Reference model
	// ========================================

	// Truncating division on magnitudes, remainder signed like the dividend
	function automatic divResult expectedResult(input divReq r);
		divResult e;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] magA;
		logic [dataWidth-1:0] magB;
		logic negA;
		logic negB;
		b = (r.op == divSignedImm) ? r.imm : r.divisor;
		negA = (r.op != divUnsigned) && r.dividend[dataWidth-1];
		negB = (r.op != divUnsigned) && b[dataWidth-1];
		magA = negA ? (~r.dividend + 1'b1) : r.dividend;
		magB = negB ? (~b + 1'b1) : b;
		e.tag = r.tag;
		if (b == '0) begin
			e.quotient = '1;
			e.remainder = r.dividend;
			e.divByZero = 1'b1;
		end else begin
			e.quotient = (negA ^ negB) ? -(magA / magB) : (magA / magB);
			e.remainder = negA ? -(magA % magB) : (magA % magB);
			e.divByZero = 1'b0;
		end
		return e;
	endfunction

	function automatic divReq makeReq(input logic [tagWidth-1:0] tag, input divOp op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
			input logic [dataWidth-1:0] imm);
		divReq r;
		r.tag = tag;
		r.op = op;
		r.dividend = a;
		r.divisor = b;
		r.imm = imm;
		return r;
	endfunction

	function automatic logic [dataWidth-1:0] nextRandom();
		return {$random(seed), $random(seed)};
	endfunction

	// Mixed opcodes, divisors of random length and sign
	function automatic divReq randomReq(input logic [tagWidth-1:0] tag);
		divReq r;
		int shift;
		r.tag = tag;
		r.op = divOp'(2'($unsigned($random(seed)) % 3));
		r.dividend = nextRandom();
		shift = $unsigned($random(seed)) % 64;
		r.divisor = nextRandom() >> shift;
		r.imm = nextRandom() >> (63 - shift);
		if ($random(seed) & 1) begin
			r.divisor = -r.divisor;
		end
		return r;
	endfunction

	function automatic int totalFailures();
		return errors + uut.chk.failCount;
	endfunction

	// ========================================
	// Stimulus and checking tasks
	// ========================================

	// Waits for a free unit, then strobes one request
	task automatic sendReq(input divReq r);
		@(negedge clk);
		while (busy) @(negedge clk);
		req = r;
		reqValid = 1'b1;
		expQ.push_back(expectedResult(r));
		accepted++;
		@(negedge clk);
		reqValid = 1'b0;
	endtask

	// Request strobe while busy, must vanish
	task automatic strobeWhileBusy(input divReq r);
		req = r;
		reqValid = 1'b1;
		@(negedge clk);
		reqValid = 1'b0;
	endtask

	task automatic checkField(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got == exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic startTest();
		failsBefore = totalFailures();
		testsRun++;
	endtask

	task automatic endTest(input string name);
		while (expQ.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);
		if (totalFailures() != failsBefore) begin
			testsFailed++;
			$display("Test %0d %s: failed", testsRun, name);
		end else begin
			$display("Test %0d %s: passed", testsRun, name);
		end
	endtask

	// Result strobe is stable across the falling edge
	always @(negedge clk) begin
		if (!rst && resultValid) begin
			resultCount++;
			if (expQ.size() == 0) begin
				$display("Result with tag %0d at %0t has no outstanding request",
					result.tag, $time);
				errors++;
			end else begin
				want = expQ.pop_front();
				checkField("tag", 64'(result.tag), 64'(want.tag));
				checkField("quotient", result.quotient, want.quotient);
				checkField("remainder", result.remainder, want.remainder);
				checkField("divByZero", 64'(result.divByZero), 64'(want.divByZero));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, results stopped arriving", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		startTest();
		sendReq(makeReq(6'd1, divUnsigned, 64'd10005, 64'd27, 64'd0));
		sendReq(makeReq(6'd2, divUnsigned, '1, 64'd1, 64'd0));
		sendReq(makeReq(6'd3, divUnsigned, 64'd12, 64'h8000_0000_0000_0001, 64'd0));
		endTest("unsigned directed");

		// All four sign pairs, then the wrapping overflow case
		startTest();
		sendReq(makeReq(6'd4, divSigned, 64'd100, 64'd7, 64'd0));
		sendReq(makeReq(6'd5, divSigned, -64'd100, 64'd7, 64'd0));
		sendReq(makeReq(6'd6, divSigned, 64'd100, -64'd7, 64'd0));
		sendReq(makeReq(6'd7, divSigned, -64'd100, -64'd7, 64'd0));
		sendReq(makeReq(6'd8, divSigned, 64'h8000_0000_0000_0000, '1, 64'd0));
		endTest("signed sign combinations");

		startTest();
		sendReq(makeReq(6'd9, divSignedImm, -64'd1000, 64'd3, 64'd7));
		sendReq(makeReq(6'd10, divSignedImm, 64'd5000, 64'd0, -64'd9));
		endTest("signed by immediate");

		startTest();
		sendReq(makeReq(6'd11, divSigned, -64'd77, 64'd0, 64'd5));
		sendReq(makeReq(6'd12, divSignedImm, 64'd123, 64'd4, 64'd0));
		sendReq(makeReq(6'd13, divUnsigned, 64'hdead_beef, 64'd0, 64'd0));
		endTest("divide by zero");

		startTest();
		for (int i = 0; i < 200; i++) begin
			sendReq(randomReq(6'(i)));
		end
		endTest("random back to back");

		// Strobes during a divide leave no result behind
		startTest();
		sendReq(makeReq(6'd20, divUnsigned, 64'd1000, 64'd10, 64'd0));
		repeat (10) @(negedge clk);
		strobeWhileBusy(makeReq(6'd60, divUnsigned, 64'd9, 64'd3, 64'd0));
		sendReq(makeReq(6'd21, divSigned, -64'd50, 64'd6, 64'd0));
		repeat (30) @(negedge clk);
		strobeWhileBusy(makeReq(6'd61, divSignedImm, 64'd9, 64'd3, 64'd2));
		sendReq(makeReq(6'd22, divUnsigned, 64'd81, 64'd9, 64'd0));
		while (expQ.size() != 0) @(negedge clk);
		repeat (70) @(negedge clk);
		assert (resultCount == accepted) else begin
			$display("Got %0d results for %0d accepted requests", resultCount, accepted);
			errors++;
		end
		endTest("request while busy");

		$display("Tests run %0d, tests failed %0d, checks failed %0d, results %0d",
			testsRun, testsFailed, totalFailures(), resultCount);
		if (totalFailures() == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- divUnit.f
source/divPkg.sv
source/divOperandSelect.sv
source/divCore.sv
source/divResultFormat.sv
source/divUnit.sv
tests/divUnit_chk.sv
tests/divUnitTb.sv

//--- run.sh
#!/bin/sh
# Builds the divide unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -Wno-fatal --top-module divUnitTb \
	-f divUnit.f -o divUnitSim > build.log 2>&1 &&
./obj_dir/divUnitSim +verilator+error+limit+1000 > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log && echo "Simulation passed" ||
{ echo "Simulation reported failure"; exit 1; }
